/* trig_pkg.sv */
package trig_pkg;

    // one trigger word per board per frame
    localparam int WORD_W  = 16;
    // frame counter and trigger time
    localparam int FRAME_W = 12;
    // trigger type carried in the header
    localparam int TYPE_W  = 3;
    // sub-frame time carried in the header
    localparam int SUBT_W  = 12;

    // header view of a trigger word
    // top bit marks a header, the rest is type and sub-frame time
    typedef struct packed {
        logic              hdr_flag;
        logic [TYPE_W-1:0] trig_type;
        logic [SUBT_W-1:0] sub_time;
    } trig_hdr_t;

    // one word read two ways
    // first frame of a message decodes as header
    // second frame is opaque metadata, top bit included
    typedef union packed {
        trig_hdr_t         hdr;
        logic [WORD_W-1:0] meta;
    } trig_word_u;

    // aligner to lane
    // strobe is high for one cycle per frame
    typedef struct packed {
        logic               strobe;
        trig_word_u         word;
        logic [FRAME_W-1:0] frame;
    } lane_beat_t;

    // lane to merger
    // hit pulses once when the metadata word closes a message
    typedef struct packed {
        logic               hit;
        // frame number of the header word
        logic [FRAME_W-1:0] frame;
        logic [TYPE_W-1:0]  trig_type;
        logic [SUBT_W-1:0]  sub_time;
        logic [WORD_W-1:0]  meta;
    } lane_event_t;

    // merged trigger record
    // the hit mask travels on its own port since its width follows NSURF
    typedef struct packed {
        // header frame minus the programmable offset
        logic [FRAME_W-1:0] trig_time;
        logic [TYPE_W-1:0]  trig_type;
        logic [SUBT_W-1:0]  sub_time;
        logic [WORD_W-1:0]  meta;
    } trig_rec_t;

endpackage

/* trig_frame_aligner.sv */
`timescale 1ns/10ps
module trig_frame_aligner #(
    parameter int NSURF = 8
) (
    input  logic                                sys_clk,
    input  logic                                runrst,
    // all boards, board n at bits n*WORD_W
    input  logic [NSURF*trig_pkg::WORD_W-1:0]   trig_dat_i,
    // one-cycle pulse, every 4th cycle
    input  logic                                trig_dat_valid_i,
    output trig_pkg::lane_beat_t [NSURF-1:0]    beat_o
);

    // running frame number
    logic [trig_pkg::FRAME_W-1:0] frame_cnt_q;
    // frame number stamped on the captured words
    logic [trig_pkg::FRAME_W-1:0] frame_stamp_q;
    // one-cycle beat strobe shared by all lanes
    logic                         beat_stb_q;
    // captured word per board
    trig_pkg::trig_word_u [NSURF-1:0] word_q;

    // frame counter and beat strobe
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            frame_cnt_q <= '0;
            beat_stb_q  <= 1'b0;
        end else begin
            // strobe follows the frame pulse by one cycle
            beat_stb_q <= trig_dat_valid_i;
            // first frame after reset is numbered 0
            if (trig_dat_valid_i) begin
                frame_cnt_q <= frame_cnt_q + 1'b1;
            end
        end
    end

    // stamp taken before the increment
    always_ff @(posedge sys_clk) begin
        if (trig_dat_valid_i) begin
            frame_stamp_q <= frame_cnt_q;
        end
    end

    // capture every board on the frame pulse
    always_ff @(posedge sys_clk) begin
        if (trig_dat_valid_i) begin
            for (int n = 0; n < NSURF; n++) begin
                word_q[n] <= trig_dat_i[n*trig_pkg::WORD_W +: trig_pkg::WORD_W];
            end
        end
    end

    // fan out
    // all lanes see the same strobe and frame, only the word differs
    always_comb begin
        for (int n = 0; n < NSURF; n++) begin
            beat_o[n].strobe = beat_stb_q;
            beat_o[n].word   = word_q[n];
            beat_o[n].frame  = frame_stamp_q;
        end
    end

endmodule

/* surf_trig_lane.sv */
`timescale 1ns/10ps
module surf_trig_lane (
    input  logic                  sys_clk,
    input  logic                  runrst,
    input  trig_pkg::lane_beat_t  beat_i,
    // this board's mask bit
    // loaded on the update strobe
    input  logic                  mask_i,
    input  logic                  mask_update_i,
    output trig_pkg::lane_event_t event_o
);

    // set means the board is ignored
    logic                         mask_q;
    // header seen so the next beat is metadata
    logic                         pend_q;
    // stored header fields
    logic [trig_pkg::TYPE_W-1:0]  hdr_type_q;
    logic [trig_pkg::SUBT_W-1:0]  hdr_subt_q;
    logic [trig_pkg::FRAME_W-1:0] hdr_frame_q;
    // event outputs
    logic                         hit_q;
    logic [trig_pkg::FRAME_W-1:0] ev_frame_q;
    logic [trig_pkg::TYPE_W-1:0]  ev_type_q;
    logic [trig_pkg::SUBT_W-1:0]  ev_subt_q;
    logic [trig_pkg::WORD_W-1:0]  ev_meta_q;

    // idle lane and a header word
    logic take_hdr;
    // pending header and any word
    logic take_meta;

    assign take_hdr  = beat_i.strobe && !mask_q && !pend_q && beat_i.word.hdr.hdr_flag;
    // top bit does not matter here
    assign take_meta = beat_i.strobe && !mask_q && pend_q;

    // mask register
    // reset masks every board
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            mask_q <= 1'b1;
        end else if (mask_update_i) begin
            mask_q <= mask_i;
        end
    end

    // two-word message FSM
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            pend_q <= 1'b0;
            hit_q  <= 1'b0;
        end else begin
            hit_q <= take_meta;
            if (mask_q) begin
                // masked board drops a half message
                pend_q <= 1'b0;
            end else if (take_hdr) begin
                pend_q <= 1'b1;
            end else if (take_meta) begin
                pend_q <= 1'b0;
            end
        end
    end

    // header hold
    always_ff @(posedge sys_clk) begin
        if (take_hdr) begin
            hdr_type_q  <= beat_i.word.hdr.trig_type;
            hdr_subt_q  <= beat_i.word.hdr.sub_time;
            hdr_frame_q <= beat_i.frame;
        end
    end

    // event payload
    // frame is the header's and not the metadata's
    always_ff @(posedge sys_clk) begin
        if (take_meta) begin
            ev_frame_q <= hdr_frame_q;
            ev_type_q  <= hdr_type_q;
            ev_subt_q  <= hdr_subt_q;
            ev_meta_q  <= beat_i.word.meta;
        end
    end

    always_comb begin
        event_o.hit       = hit_q;
        event_o.frame     = ev_frame_q;
        event_o.trig_type = ev_type_q;
        event_o.sub_time  = ev_subt_q;
        event_o.meta      = ev_meta_q;
    end

endmodule

/* trig_merge.sv */
`timescale 1ns/10ps
module trig_merge #(
    parameter int NSURF = 8
) (
    input  logic                                sys_clk,
    input  logic                                runrst,
    input  trig_pkg::lane_event_t [NSURF-1:0]   event_i,
    // subtracted from the header frame
    input  logic [trig_pkg::FRAME_W-1:0]        trig_offset_i,
    output logic                                trig_valid_o,
    output logic [NSURF-1:0]                    trig_hitmask_o,
    output trig_pkg::trig_rec_t                 trig_rec_o
);

    // reduction of the current cycle
    logic [NSURF-1:0]    hit_vec;
    // lowest hitting lane, time still raw frame
    trig_pkg::trig_rec_t sel_rec;

    // stage 1
    logic                s1_vld_q;
    logic [NSURF-1:0]    s1_mask_q;
    trig_pkg::trig_rec_t s1_rec_q;

    // stage 2 outputs
    logic                out_vld_q;
    logic [NSURF-1:0]    out_mask_q;
    trig_pkg::trig_rec_t out_rec_q;

    // gather hits and pick the lowest index
    // walk downward so the last match wins
    always_comb begin
        hit_vec = '0;
        sel_rec = '0;
        for (int n = NSURF - 1; n >= 0; n--) begin
            hit_vec[n] = event_i[n].hit;
            if (event_i[n].hit) begin
                sel_rec.trig_time = event_i[n].frame;
                sel_rec.trig_type = event_i[n].trig_type;
                sel_rec.sub_time  = event_i[n].sub_time;
                sel_rec.meta      = event_i[n].meta;
            end
        end
    end

    // stage 1 control
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            s1_vld_q <= 1'b0;
        end else begin
            // any lane finishing this frame
            s1_vld_q <= |hit_vec;
        end
    end

    // stage 1 payload
    always_ff @(posedge sys_clk) begin
        s1_mask_q <= hit_vec;
        s1_rec_q  <= sel_rec;
    end

    // stage 2 control
    always_ff @(posedge sys_clk) begin
        if (runrst) begin
            out_vld_q <= 1'b0;
        end else begin
            out_vld_q <= s1_vld_q;
        end
    end

    // stage 2 payload
    // output holds the last record between pulses
    always_ff @(posedge sys_clk) begin
        if (s1_vld_q) begin
            out_mask_q <= s1_mask_q;
            // wraps modulo 4096
            out_rec_q.trig_time <= s1_rec_q.trig_time - trig_offset_i;
            out_rec_q.trig_type <= s1_rec_q.trig_type;
            out_rec_q.sub_time  <= s1_rec_q.sub_time;
            out_rec_q.meta      <= s1_rec_q.meta;
        end
    end

    assign trig_valid_o   = out_vld_q;
    assign trig_hitmask_o = out_mask_q;
    assign trig_rec_o     = out_rec_q;

endmodule

/* trig_process_top.sv */
`timescale 1ns/10ps
module trig_process_top #(
    parameter int NSURF = 8
) (
    input  logic                              sys_clk,
    input  logic                              runrst,
    // board words, flat
    input  logic [NSURF*trig_pkg::WORD_W-1:0] trig_dat_i,
    input  logic                              trig_dat_valid_i,
    // per-board mask, loaded on the strobe
    input  logic [NSURF-1:0]                  trigmask_i,
    input  logic                              trigmask_update_i,
    input  logic [trig_pkg::FRAME_W-1:0]      trig_offset_i,
    output logic                              trig_valid_o,
    output logic [NSURF-1:0]                  trig_hitmask_o,
    output trig_pkg::trig_rec_t               trig_rec_o
);

    // aligner to lanes
    trig_pkg::lane_beat_t  [NSURF-1:0] beat;
    // lanes to merger
    trig_pkg::lane_event_t [NSURF-1:0] lane_event;

    // frame counter and word capture
    trig_frame_aligner #(
        .NSURF (NSURF)
    ) u_aligner (
        .sys_clk          (sys_clk),
        .runrst           (runrst),
        .trig_dat_i       (trig_dat_i),
        .trig_dat_valid_i (trig_dat_valid_i),
        .beat_o           (beat)
    );

    // one decoder per board
    for (genvar n = 0; n < NSURF; n++) begin : g_lane
        surf_trig_lane u_lane (
            .sys_clk       (sys_clk),
            .runrst        (runrst),
            .beat_i        (beat[n]),
            .mask_i        (trigmask_i[n]),
            .mask_update_i (trigmask_update_i),
            .event_o       (lane_event[n])
        );
    end

    // same-frame events into one record
    trig_merge #(
        .NSURF (NSURF)
    ) u_merge (
        .sys_clk        (sys_clk),
        .runrst         (runrst),
        .event_i        (lane_event),
        .trig_offset_i  (trig_offset_i),
        .trig_valid_o   (trig_valid_o),
        .trig_hitmask_o (trig_hitmask_o),
        .trig_rec_o     (trig_rec_o)
    );

endmodule

/* tb_trig_process.sv */
`timescale 1ns/10ps
module tb_trig_process;

    localparam int NSURF = 8;
    localparam int WW = trig_pkg::WORD_W;
    // frames per test phase
    localparam int RAND_FRAMES = 300;
    localparam int DRAIN_FRAMES = 8;

    // expected record and the edge index it is due at
    typedef struct packed {
        logic [31:0]         due;
        logic [NSURF-1:0]    mask;
        trig_pkg::trig_rec_t rec;
    } exp_t;

    logic                  sys_clk = 1'b0;
    logic                  runrst;
    logic [NSURF*WW-1:0]   trig_dat_i;
    logic                  trig_dat_valid_i;
    logic [NSURF-1:0]      trigmask_i;
    logic                  trigmask_update_i;
    logic [11:0]           trig_offset_i;
    logic                  trig_valid_o;
    logic [NSURF-1:0]      trig_hitmask_o;
    trig_pkg::trig_rec_t   trig_rec_o;

    // edge counter
    // read at an edge it gives that edge's index
    int unsigned           cyc_cnt = 0;
    exp_t                  exp_q [$];
    int                    pushed_cnt = 0;
    // last record seen on the outputs
    int                    seen_cnt = 0;
    logic [NSURF-1:0]      seen_mask;
    trig_pkg::trig_rec_t   seen_rec;

    // reference model state
    logic [NSURF-1:0]      ref_mask;
    logic [NSURF-1:0]      ref_pend;
    trig_pkg::trig_hdr_t   ref_hdr [NSURF];
    logic [11:0]           ref_hdr_frame [NSURF];
    logic [11:0]           ref_frame_cnt;
    logic [15:0]           lfsr_q;

    trig_process_top #(
        .NSURF (NSURF)
    ) UUT (
        .sys_clk           (sys_clk),
        .runrst            (runrst),
        .trig_dat_i        (trig_dat_i),
        .trig_dat_valid_i  (trig_dat_valid_i),
        .trigmask_i        (trigmask_i),
        .trigmask_update_i (trigmask_update_i),
        .trig_offset_i     (trig_offset_i),
        .trig_valid_o      (trig_valid_o),
        .trig_hitmask_o    (trig_hitmask_o),
        .trig_rec_o        (trig_rec_o)
    );

    // 4 ns period
    always #2 sys_clk = ~sys_clk;

    task automatic abort_test(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_rec(input string name, input trig_pkg::trig_rec_t got,
                             input trig_pkg::trig_rec_t exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_test("record field mismatch");
        end
    endtask

    task automatic check_mask(input string name, input logic [NSURF-1:0] got,
                              input logic [NSURF-1:0] exp);
        if (got !== exp) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
            abort_test("hit mask mismatch");
        end
    endtask

    // 16-bit Galois LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_q[0]};
            lfsr_q = lfsr_next(lfsr_q);
        end
        return v;
    endfunction

    function automatic trig_pkg::trig_rec_t make_rec(input logic [11:0] t, input logic [2:0] ty,
                                                    input logic [11:0] st, input logic [15:0] m);
        trig_pkg::trig_rec_t r;
        r.trig_time = t;
        r.trig_type = ty;
        r.sub_time  = st;
        r.meta      = m;
        return r;
    endfunction

    // one frame of lane and merge rules
    // returns 1 when a record is due
    function automatic logic ref_frame(input logic [NSURF*WW-1:0] words, input logic [11:0] offset,
                                       output logic [NSURF-1:0] mask_out,
                                       output trig_pkg::trig_rec_t rec_out);
        trig_pkg::trig_word_u w;
        logic                 found;
        mask_out = '0;
        rec_out  = '0;
        found    = 1'b0;
        for (int n = 0; n < NSURF; n++) begin
            w = words[n*WW +: WW];
            if (ref_mask[n]) begin
                // masked board loses any half message
                ref_pend[n] = 1'b0;
            end else if (ref_pend[n]) begin
                // second word is metadata whatever its top bit
                mask_out[n] = 1'b1;
                if (!found) begin
                    found   = 1'b1;
                    rec_out = make_rec(ref_hdr_frame[n] - offset, ref_hdr[n].trig_type,
                                       ref_hdr[n].sub_time, w.meta);
                end
                ref_pend[n] = 1'b0;
            end else if (w.hdr.hdr_flag) begin
                ref_pend[n]      = 1'b1;
                ref_hdr[n]       = w.hdr;
                ref_hdr_frame[n] = ref_frame_cnt;
            end
        end
        ref_frame_cnt = ref_frame_cnt + 1'b1;
        return found;
    endfunction

    // 4-cycle frame with valid on the first cycle and mask strobe on the third
    task automatic run_frame(input logic [NSURF*WW-1:0] words, input logic [11:0] offset,
                             input logic mask_upd, input logic [NSURF-1:0] mask_val);
        exp_t                e;
        logic                fired;
        logic [NSURF-1:0]    m;
        trig_pkg::trig_rec_t r;
        @(posedge sys_clk);
        trig_dat_valid_i <= 1'b1;
        trig_dat_i       <= words;
        trig_offset_i    <= offset;
        fired = ref_frame(words, offset, m, r);
        if (fired) begin
            // DUT samples valid one edge later and the record is seen 4 edges after that
            e.due  = cyc_cnt + 5;
            e.mask = m;
            e.rec  = r;
            exp_q.push_back(e);
            pushed_cnt++;
        end
        @(posedge sys_clk);
        trig_dat_valid_i <= 1'b0;
        @(posedge sys_clk);
        trigmask_update_i <= mask_upd;
        trigmask_i        <= mask_val;
        // new mask applies from the next frame on
        if (mask_upd) begin
            ref_mask = mask_val;
        end
        @(posedge sys_clk);
        trigmask_update_i <= 1'b0;
    endtask

    // idle frames until every expected record has been seen
    task automatic drain_records();
        int n;
        n = 0;
        while (exp_q.size() > 0 && n < DRAIN_FRAMES) begin
            run_frame('0, trig_offset_i, 1'b0, '0);
            n++;
        end
        if (exp_q.size() > 0) begin
            abort_test("timeout waiting for trig_valid_o of an expected record");
        end
    endtask

    // compare outputs against the queue on every edge
    always @(posedge sys_clk) begin
        cyc_cnt <= cyc_cnt + 1;
        if (!runrst) begin
            if (exp_q.size() > 0 && exp_q[0].due == cyc_cnt) begin
                if (trig_valid_o !== 1'b1) begin
                    abort_test("trig_valid_o missing when a record was due");
                end else begin
                    check_mask("trig_hitmask_o", trig_hitmask_o, exp_q[0].mask);
                    check_rec("trig_rec_o", trig_rec_o, exp_q[0].rec);
                    seen_mask = trig_hitmask_o;
                    seen_rec  = trig_rec_o;
                    seen_cnt++;
                    void'(exp_q.pop_front());
                end
            end else if (trig_valid_o !== 1'b0) begin
                abort_test("trig_valid_o pulsed with no record expected");
            end
        end
    end

    initial begin
        logic [NSURF*WW-1:0] words;
        logic [11:0]         hf;
        int                  start_cnt;
        runrst            <= 1'b1;
        trig_dat_i        <= '0;
        trig_dat_valid_i  <= 1'b0;
        trigmask_i        <= '0;
        trigmask_update_i <= 1'b0;
        trig_offset_i     <= '0;
        ref_mask      = '1;
        ref_pend      = '0;
        ref_frame_cnt = '0;
        lfsr_q        = 16'd31261;
        for (int i = 0; i < 5; i++) begin
            @(posedge sys_clk);
        end
        runrst <= 1'b0;

        // all boards masked out of reset
        run_frame({NSURF{16'h8123}}, 12'h000, 1'b0, '0);
        run_frame({NSURF{16'h0456}}, 12'h000, 1'b0, '0);
        drain_records();
        if (seen_cnt != 0) begin
            abort_test("record issued while every board was masked");
        end

        // board 0 alone
        run_frame('0, 12'h000, 1'b1, 8'hFE);
        hf    = ref_frame_cnt;
        words = '0;
        words[0 +: WW] = 16'h8010;
        run_frame(words, 12'h000, 1'b0, '0);
        words[0 +: WW] = 16'h00AA;
        run_frame(words, 12'h000, 1'b0, '0);
        drain_records();
        if (seen_cnt != 1) begin
            abort_test("board 0 message did not give exactly one record");
        end
        check_mask("trig_hitmask_o", seen_mask, 8'h01);
        check_rec("trig_rec_o", seen_rec, make_rec(hf, 3'd0, 12'h010, 16'h00AA));

        // boards 2 5 and 6 share a frame and board 2 wins
        run_frame('0, 12'h000, 1'b1, '0);
        hf    = ref_frame_cnt;
        words = '0;
        words[2*WW +: WW] = 16'h9ABC;
        words[5*WW +: WW] = 16'hC0DE;
        words[6*WW +: WW] = 16'hFFFF;
        run_frame(words, 12'h000, 1'b0, '0);
        for (int n = 0; n < NSURF; n++) begin
            words[n*WW +: WW] = 16'h0100 + 16'(n);
        end
        // header-like word in the metadata slot
        words[2*WW +: WW] = 16'hF00D;
        run_frame(words, 12'h000, 1'b0, '0);
        drain_records();
        check_mask("trig_hitmask_o", seen_mask, 8'h64);
        check_rec("trig_rec_o", seen_rec, make_rec(hf, 3'd1, 12'hABC, 16'hF00D));

        // offset larger than the frame number wraps
        hf    = ref_frame_cnt;
        words = '0;
        words[1*WW +: WW] = 16'hB456;
        run_frame(words, 12'hF00, 1'b0, '0);
        words[1*WW +: WW] = 16'h1234;
        run_frame(words, 12'hF00, 1'b0, '0);
        drain_records();
        check_mask("trig_hitmask_o", seen_mask, 8'h02);
        check_rec("trig_rec_o", seen_rec, make_rec(hf - 12'hF00, 3'd3, 12'h456, 16'h1234));

        // random words, offsets and mask updates
        start_cnt = pushed_cnt;
        for (int f = 0; f < RAND_FRAMES; f++) begin
            for (int n = 0; n < NSURF; n++) begin
                words[n*WW +: WW] = 16'(rand_bits(16));
            end
            run_frame(words, 12'(rand_bits(12)), 2'(rand_bits(2)) == 2'b11,
                      NSURF'(rand_bits(NSURF)));
        end
        // close half messages, then empty the queue
        run_frame('0, trig_offset_i, 1'b0, '0);
        run_frame('0, trig_offset_i, 1'b0, '0);
        drain_records();

        if (pushed_cnt - start_cnt < 20) begin
            abort_test("random phase produced too few records");
        end else begin
            $display("Test passed");
            $finish;
        end
    end

endmodule

/* files.f */
trig_pkg.sv
trig_frame_aligner.sv
surf_trig_lane.sv
trig_merge.sv
trig_process_top.sv
tb_trig_process.sv

/* Makefile */
# Verilator build and run for the trigger front end

VERILATOR ?= verilator
VFLAGS    ?= --timing
TOP       ?= tb_trig_process
FILELIST  ?= files.f
OBJDIR    ?= obj_dir
PASS_MSG  := Test passed

.PHONY: all lint sim clean

all: sim

# static checks over the whole file list
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
